/* design/mips_frontend_settings.svh */
// build-time sizes for the front end, included by any file that needs them.
`ifndef MIPS_FRONTEND_SETTINGS_SVH
`define MIPS_FRONTEND_SETTINGS_SVH

// fetch queue entries, power of two.
`define FQ_DEPTH 4

// address of the first fetch after reset.
`define RESET_PC 32'h0000_0000

`endif

/* design/mips_frontend_pkg.sv */
// shared opcode constants and struct types for the fetch, queue and decode front end.
`default_nettype none

package mips_frontend_pkg;

    // primary opcodes, bits 31:26.
    localparam logic [5:0] OP_SPECIAL = 6'd0;
    localparam logic [5:0] OP_REGIMM  = 6'd1;
    localparam logic [5:0] OP_J       = 6'd2;
    localparam logic [5:0] OP_JAL     = 6'd3;
    localparam logic [5:0] OP_ANDI    = 6'd12;
    localparam logic [5:0] OP_ORI     = 6'd13;
    localparam logic [5:0] OP_XORI    = 6'd14;

    // function code of jalr under OP_SPECIAL.
    localparam logic [5:0] FN_JALR    = 6'd9;

    // regimm rt codes that write the link register.
    localparam logic [4:0] RT_BLTZAL  = 5'd16;
    localparam logic [4:0] RT_BGEZAL  = 5'd17;

    // one fetched word with its address.
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instr;
    } fetch_entry_t;

    // decoded instruction as seen by the back end.
    typedef struct packed {
        logic [31:0] pc;
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  shamt;
        logic [5:0]  funct;
        logic [25:0] target;
        logic [31:0] sign_imm;
        logic        is_r_type;
        logic        is_i_type;
        logic        is_j_type;
        logic        use_link_reg;
    } dec_instr_t;

endpackage

`default_nettype wire

/* design/fetch_unit.sv */
// sequential instruction fetch: program counter, memory request and queue push.
`timescale 1ns/1ps
`default_nettype none

`include "mips_frontend_settings.svh"

module fetch_unit (
    input  wire logic                           clk_i,
    input  wire logic                           rst_i,
    input  wire logic                           run_i,
    input  wire logic                           full_i,
    input  wire logic [31:0]                    imem_rdata_i,
    output logic                                imem_req_o,
    output logic [31:0]                         imem_addr_o,
    output logic                                push_o,
    output mips_frontend_pkg::fetch_entry_t     entry_o
);

    import mips_frontend_pkg::*;

    logic [31:0] pc_q;
    logic        active_q;
    logic        fetch_en;

    // goes high one edge after reset is released.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            active_q <= 1'b0;
        end else begin
            active_q <= 1'b1;
        end
    end

    // no fetch while the queue cannot take the word.
    assign fetch_en = active_q & run_i & ~full_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pc_q <= `RESET_PC;
        end else if (fetch_en) begin
            pc_q <= pc_q + 32'd4;
        end
    end

    assign imem_req_o  = fetch_en;
    assign imem_addr_o = pc_q;
    assign push_o      = fetch_en;

    // memory answers in the same cycle.
    always_comb begin
        entry_o       = '0;
        entry_o.pc    = pc_q;
        entry_o.instr = imem_rdata_i;
    end

endmodule

`default_nettype wire

/* design/fetch_queue.sv */
// synchronous circular FIFO between fetch and decode, payload type set by parameter.
`timescale 1ns/1ps
`default_nettype none

`include "mips_frontend_settings.svh"

module fetch_queue #(
    parameter type T = mips_frontend_pkg::fetch_entry_t
) (
    input  wire logic clk_i,
    input  wire logic rst_i,
    input  wire logic push_i,
    input  wire logic pop_i,
    input  wire T     wdata_i,
    output T          rdata_o,
    output logic      full_o,
    output logic      empty_o
);

    localparam int DEPTH = `FQ_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = PTR_W + 1;

    T mem_q [DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             push_ok;
    logic             pop_ok;

    assign full_o  = (count_q == CNT_W'(DEPTH));
    assign empty_o = (count_q == '0);

    // ignore strobes the queue cannot honour.
    assign push_ok = push_i & ~full_o;
    assign pop_ok  = pop_i & ~empty_o;

    always_ff @(posedge clk_i) begin
        if (push_ok) begin
            mem_q[wr_ptr_q] <= wdata_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({push_ok, pop_ok})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // head entry, only meaningful while not empty.
    assign rdata_o = mem_q[rd_ptr_q];

endmodule

`default_nettype wire

/* design/decode.sv */
// combinational MIPS field decoder: slices, class flags, immediate extension and link detect.
`timescale 1ns/1ps
`default_nettype none

module decode (
    input  wire logic [31:0]                instr_dec_i,
    input  wire logic                       sign_ext_i,
    input  wire logic [31:0]                pc_i,
    output mips_frontend_pkg::dec_instr_t   dec_o
);

    import mips_frontend_pkg::*;

    logic [5:0] op;
    logic [4:0] rt;
    logic [5:0] funct;
    logic       is_r;
    logic       is_j;
    logic       regimm_link;

    assign op    = instr_dec_i[31:26];
    assign rt    = instr_dec_i[20:16];
    assign funct = instr_dec_i[5:0];

    assign is_r = (op == OP_SPECIAL);
    assign is_j = (op == OP_J) || (op == OP_JAL);

    // bltzal and bgezal.
    assign regimm_link = (op == OP_REGIMM) && ((rt == RT_BLTZAL) || (rt == RT_BGEZAL));

    always_comb begin
        dec_o        = '0;
        dec_o.pc     = pc_i;
        dec_o.op     = op;
        dec_o.rs     = instr_dec_i[25:21];
        dec_o.rt     = rt;
        dec_o.rd     = instr_dec_i[15:11];
        dec_o.shamt  = instr_dec_i[10:6];
        dec_o.funct  = funct;
        dec_o.target = instr_dec_i[25:0];

        if (sign_ext_i) begin
            dec_o.sign_imm = {{16{instr_dec_i[15]}}, instr_dec_i[15:0]};
        end else begin
            dec_o.sign_imm = {16'h0000, instr_dec_i[15:0]};
        end

        dec_o.is_r_type = is_r;
        dec_o.is_j_type = is_j;
        // anything that is neither special nor a jump.
        dec_o.is_i_type = ~is_r & ~is_j;

        dec_o.use_link_reg = regimm_link
                           | (is_r & (funct == FN_JALR))
                           | (op == OP_JAL);
    end

endmodule

`default_nettype wire

/* design/decode_stage.sv */
// decode pipeline stage: pops the fetch queue, decodes the head and registers the result.
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  wire logic                           clk_i,
    input  wire logic                           rst_i,
    input  wire logic                           hold_i,
    input  wire logic                           empty_i,
    input  wire mips_frontend_pkg::fetch_entry_t entry_i,
    output logic                                pop_o,
    output mips_frontend_pkg::dec_instr_t       dec_o,
    output logic                                dec_valid_o
);

    import mips_frontend_pkg::*;

    logic [5:0]  head_op;
    logic        sign_ext;
    dec_instr_t  dec_comb;
    dec_instr_t  dec_q;
    logic        valid_q;

    assign pop_o = ~empty_i & ~hold_i;

    // logical immediates are zero extended.
    assign head_op  = entry_i.instr[31:26];
    assign sign_ext = ~((head_op == OP_ANDI) || (head_op == OP_ORI) || (head_op == OP_XORI));

    decode u_decode (
        .instr_dec_i (entry_i.instr),
        .sign_ext_i  (sign_ext),
        .pc_i        (entry_i.pc),
        .dec_o       (dec_comb)
    );

    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            dec_q <= dec_comb;
        end
    end

    // one pulse per popped entry.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= pop_o;
        end
    end

    assign dec_o       = dec_q;
    assign dec_valid_o = valid_q;

endmodule

`default_nettype wire

/* design/mips_frontend.sv */
// front end top level: fetch unit, fetch queue and decode stage wired in sequence.
`timescale 1ns/1ps
`default_nettype none

module mips_frontend (
    input  wire logic                       clk_i,
    input  wire logic                       rst_i,
    input  wire logic                       run_i,
    input  wire logic                       hold_i,
    input  wire logic [31:0]                imem_rdata_i,
    output logic                            imem_req_o,
    output logic [31:0]                     imem_addr_o,
    output mips_frontend_pkg::dec_instr_t   dec_o,
    output logic                            dec_valid_o
);

    import mips_frontend_pkg::*;

    logic         push;
    logic         pop;
    logic         full;
    logic         empty;
    fetch_entry_t fetch_entry;
    fetch_entry_t head_entry;

    fetch_unit u_fetch_unit (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .run_i        (run_i),
        .full_i       (full),
        .imem_rdata_i (imem_rdata_i),
        .imem_req_o   (imem_req_o),
        .imem_addr_o  (imem_addr_o),
        .push_o       (push),
        .entry_o      (fetch_entry)
    );

    fetch_queue #(
        .T (fetch_entry_t)
    ) u_fetch_queue (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .push_i  (push),
        .pop_i   (pop),
        .wdata_i (fetch_entry),
        .rdata_o (head_entry),
        .full_o  (full),
        .empty_o (empty)
    );

    decode_stage u_decode_stage (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .hold_i      (hold_i),
        .empty_i     (empty),
        .entry_i     (head_entry),
        .pop_o       (pop),
        .dec_o       (dec_o),
        .dec_valid_o (dec_valid_o)
    );

endmodule

`default_nettype wire

/* tb/mips_frontend_props.sv */
// concurrent checks on fetch queue strobes and flags, attached to every fetch_queue by bind.
`timescale 1ns/1ps
`default_nettype none

`include "mips_frontend_settings.svh"

module mips_frontend_props (
    input wire logic clk_i,
    input wire logic rst_i,
    input wire logic push_i,
    input wire logic pop_i,
    input wire logic full_i,
    input wire logic empty_i
);

    localparam int DEPTH = `FQ_DEPTH;
    localparam int LVL_W = $clog2(DEPTH) + 1;

    logic [LVL_W-1:0] level_q;

    // shadow occupancy from the strobes.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            level_q <= '0;
        end else if (push_i && !pop_i) begin
            level_q <= level_q + LVL_W'(1);
        end else if (pop_i && !push_i) begin
            level_q <= level_q - LVL_W'(1);
        end
    end

    push_not_full: assert property (@(posedge clk_i) disable iff (rst_i) push_i |-> !full_i)
        else $error("fetch queue push while full");

    pop_not_empty: assert property (@(posedge clk_i) disable iff (rst_i) pop_i |-> !empty_i)
        else $error("fetch queue pop while empty");

    flags_exclusive: assert property (@(posedge clk_i) !(full_i && empty_i))
        else $error("fetch queue full and empty together");

    empty_after_reset: assert property (@(posedge clk_i) rst_i |=> empty_i)
        else $error("fetch queue not empty after reset");

    flags_track_level: assert property (@(posedge clk_i) disable iff (rst_i)
        (full_i == (level_q == LVL_W'(DEPTH))) && (empty_i == (level_q == '0)))
        else $error("fetch queue flags disagree with occupancy");

endmodule

bind fetch_queue mips_frontend_props u_fetch_queue_props (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (push_i),
    .pop_i   (pop_i),
    .full_i  (full_o),
    .empty_i (empty_o)
);

`default_nettype wire

/* tb/mips_frontend_tb.sv */
// front end testbench that serves a program table as instruction memory and checks decode order.
`timescale 1ns/1ps
`default_nettype none

`include "mips_frontend_settings.svh"

module mips_frontend_tb;

    import mips_frontend_pkg::*;

    localparam int PROG_LEN = 16;
    localparam int DEPTH = `FQ_DEPTH;
    localparam int TIMEOUT_CYCLES = PROG_LEN * (DEPTH + 8) + 100;
    localparam logic [5:0] OP_ADDI = 6'd8;
    localparam logic [5:0] OP_LW   = 6'd35;
    localparam logic [5:0] OP_BEQ  = 6'd4;

    typedef struct packed {
        logic [31:0] word;
        logic        is_r;
        logic        is_i;
        logic        is_j;
        logic        link;
    } row_t;

    row_t        prog [PROG_LEN];
    logic        clk = 1'b0;
    logic        rst;
    logic        run;
    logic        hold;
    logic [31:0] imem_rdata;
    logic [31:0] imem_word_idx;
    logic        imem_req;
    logic [31:0] imem_addr;
    dec_instr_t  dec;
    logic        dec_valid;
    int          errors = 0;
    int          checks = 0;
    int          got_count = 0;
    int          since_reset = 0;
    int          hold_run = 0;
    logic        hold_last = 1'b0;
    logic        seen_req = 1'b0;
    logic [31:0] prev_addr = '0;

    mips_frontend mips_frontend_i (
        .clk_i        (clk),
        .rst_i        (rst),
        .run_i        (run),
        .hold_i       (hold),
        .imem_rdata_i (imem_rdata),
        .imem_req_o   (imem_req),
        .imem_addr_o  (imem_addr),
        .dec_o        (dec),
        .dec_valid_o  (dec_valid)
    );

    always #5 clk = ~clk;

    // word lookup with zero past the end of the table.
    always_comb begin
        imem_word_idx = imem_addr >> 2;
        if (imem_word_idx < PROG_LEN) begin
            imem_rdata = prog[imem_word_idx].word;
        end else begin
            imem_rdata = 32'h0000_0000;
        end
    end

    function automatic logic [31:0] build_r_word(input logic [4:0] rs, input logic [4:0] rt,
            input logic [4:0] rd, input logic [4:0] shamt, input logic [5:0] funct);
        return {OP_SPECIAL, rs, rt, rd, shamt, funct};
    endfunction

    function automatic logic [31:0] build_i_word(input logic [5:0] op, input logic [4:0] rs,
            input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] build_j_word(input logic [5:0] op, input logic [25:0] target);
        return {op, target};
    endfunction

    // logical immediates zero extend and all others sign extend.
    function automatic logic [31:0] expected_imm(input logic [31:0] w);
        logic [5:0] op;
        op = w[31:26];
        if (op == OP_ANDI || op == OP_ORI || op == OP_XORI) begin
            return {16'h0000, w[15:0]};
        end
        return {{16{w[15]}}, w[15:0]};
    endfunction

    task automatic load_program();
        prog[0]  = '{build_r_word(5'd8, 5'd9, 5'd10, 5'd0, 6'd32), 1'b1, 1'b0, 1'b0, 1'b0};
        prog[1]  = '{build_r_word(5'd0, 5'd4, 5'd5, 5'd7, 6'd0), 1'b1, 1'b0, 1'b0, 1'b0};
        prog[2]  = '{build_r_word(5'd4, 5'd0, 5'd31, 5'd0, FN_JALR), 1'b1, 1'b0, 1'b0, 1'b1};
        prog[3]  = '{build_j_word(OP_J, 26'h2AB_CDEF), 1'b0, 1'b0, 1'b1, 1'b0};
        prog[4]  = '{build_j_word(OP_JAL, 26'h123_4567), 1'b0, 1'b0, 1'b1, 1'b1};
        prog[5]  = '{build_i_word(OP_REGIMM, 5'd3, RT_BLTZAL, 16'hFFF0), 1'b0, 1'b1, 1'b0, 1'b1};
        prog[6]  = '{build_i_word(OP_REGIMM, 5'd7, RT_BGEZAL, 16'h0010), 1'b0, 1'b1, 1'b0, 1'b1};
        prog[7]  = '{build_i_word(OP_REGIMM, 5'd2, 5'd0, 16'h8000), 1'b0, 1'b1, 1'b0, 1'b0};
        prog[8]  = '{build_i_word(OP_ANDI, 5'd1, 5'd2, 16'hF00F), 1'b0, 1'b1, 1'b0, 1'b0};
        prog[9]  = '{build_i_word(OP_ORI, 5'd3, 5'd4, 16'h8001), 1'b0, 1'b1, 1'b0, 1'b0};
        prog[10] = '{build_i_word(OP_XORI, 5'd5, 5'd6, 16'hFFFF), 1'b0, 1'b1, 1'b0, 1'b0};
        prog[11] = '{build_i_word(OP_ADDI, 5'd9, 5'd10, 16'h7FFF), 1'b0, 1'b1, 1'b0, 1'b0};
        prog[12] = '{build_i_word(OP_ADDI, 5'd11, 5'd12, 16'hFFFE), 1'b0, 1'b1, 1'b0, 1'b0};
        prog[13] = '{build_i_word(OP_LW, 5'd29, 5'd8, 16'h8004), 1'b0, 1'b1, 1'b0, 1'b0};
        prog[14] = '{build_r_word(5'd17, 5'd18, 5'd19, 5'd3, 6'd34), 1'b1, 1'b0, 1'b0, 1'b0};
        prog[15] = '{build_i_word(OP_BEQ, 5'd1, 5'd2, 16'h0004), 1'b0, 1'b1, 1'b0, 1'b0};
    endtask

    task automatic compare_field(input string name, input logic [31:0] got,
            input logic [31:0] exp, input int idx);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("[ERROR] %0t: row %0d %s is %h, expected %h", $time, idx, name, got, exp);
        end
    endtask

    task automatic check_decoded(input int idx);
        logic [31:0] w;
        w = prog[idx].word;
        compare_field("pc", dec.pc, `RESET_PC + 32'(4 * idx), idx);
        compare_field("op", 32'(dec.op), 32'(w[31:26]), idx);
        compare_field("rs", 32'(dec.rs), 32'(w[25:21]), idx);
        compare_field("rt", 32'(dec.rt), 32'(w[20:16]), idx);
        compare_field("rd", 32'(dec.rd), 32'(w[15:11]), idx);
        compare_field("shamt", 32'(dec.shamt), 32'(w[10:6]), idx);
        compare_field("funct", 32'(dec.funct), 32'(w[5:0]), idx);
        compare_field("target", 32'(dec.target), 32'(w[25:0]), idx);
        compare_field("sign_imm", dec.sign_imm, expected_imm(w), idx);
        compare_field("is_r_type", 32'(dec.is_r_type), 32'(prog[idx].is_r), idx);
        compare_field("is_i_type", 32'(dec.is_i_type), 32'(prog[idx].is_i), idx);
        compare_field("is_j_type", 32'(dec.is_j_type), 32'(prog[idx].is_j), idx);
        compare_field("use_link_reg", 32'(dec.use_link_reg), 32'(prog[idx].link), idx);
    endtask

    // all checks sampled mid cycle.
    always @(negedge clk) begin
        if (rst || since_reset == 0) begin
            checks++;
            assert (!dec_valid && !imem_req) else begin
                errors++;
                $display("[ERROR] %0t: dec_valid_o=%b imem_req_o=%b at reset", $time,
                         dec_valid, imem_req);
            end
        end
        if (rst) begin
            since_reset = 0;
        end else begin
            hold_run = hold ? hold_run + 1 : 0;
            if (imem_req && !seen_req) begin
                compare_field("first request address", imem_addr, `RESET_PC, 0);
                seen_req = 1'b1;
            end
            if (hold_last) begin
                compare_field("dec_valid_o under hold", 32'(dec_valid), 32'd0, got_count);
            end
            // queue is full by now so fetch must be stalled.
            if (hold_run >= DEPTH + 3) begin
                compare_field("stalled address", imem_addr, prev_addr, got_count);
                compare_field("imem_req_o under stall", 32'(imem_req), 32'd0, got_count);
                if (got_count == 0) begin
                    compare_field("first stall address", imem_addr,
                                  `RESET_PC + 32'(4 * DEPTH), 0);
                end
            end
            if (dec_valid && got_count < PROG_LEN) begin
                check_decoded(got_count);
                got_count++;
            end
            since_reset++;
        end
        hold_last = hold;
        prev_addr = imem_addr;
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("run timed out after %0d cycles, %0d of %0d instructions decoded",
                 TIMEOUT_CYCLES, got_count, PROG_LEN);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin : main
        void'($urandom(32'hd29adcc7));
        rst = 1'b1;
        // fetch enabled from the start so only reset keeps it idle.
        run = 1'b1;
        hold = 1'b0;
        load_program();
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        hold = 1'b1;
        // long hold so the queue fills and fetch stalls.
        repeat (DEPTH + 6) @(posedge clk);
        #1;
        hold = 1'b0;
        while (got_count < PROG_LEN) begin
            @(posedge clk);
            #1;
            hold = ($urandom() % 32'd4) == 32'd0;
        end
        hold = 1'b0;
        repeat (2) @(posedge clk);
        $display("checks: %0d, errors: %0d, decoded: %0d of %0d",
                 checks, errors, got_count, PROG_LEN);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+design
design/mips_frontend_pkg.sv
design/fetch_unit.sv
design/fetch_queue.sv
design/decode.sv
design/decode_stage.sv
design/mips_frontend.sv
tb/mips_frontend_props.sv
tb/mips_frontend_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert --timing -j 0
TOP       := mips_frontend_tb
FILELIST  := verilog.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := *** FAILED ***
PASS_MSG  := *** PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -qF '$(PASS_MSG)' $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
